// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

  // Datapath widths
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_idx_t;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

  // Major opcodes handled by decode
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // Class codes in the low field of the execute-info word
  localparam logic [2:0] EXU_CLASS_ALU = 3'b001;
  localparam logic [2:0] EXU_CLASS_BJP = 3'b010;

  localparam int ALU_OP_W = 12;
  localparam int BJP_OP_W = 8;

  // One-hot positions in the alu view flag field
  localparam int EXU_ALU_ADD    = 0;
  localparam int EXU_ALU_SUB    = 1;
  localparam int EXU_ALU_SLL    = 2;
  localparam int EXU_ALU_SLT    = 3;
  localparam int EXU_ALU_SLTU   = 4;
  localparam int EXU_ALU_XOR    = 5;
  localparam int EXU_ALU_SRL    = 6;
  localparam int EXU_ALU_SRA    = 7;
  localparam int EXU_ALU_OR     = 8;
  localparam int EXU_ALU_AND    = 9;
  localparam int EXU_ALU_LUI    = 10;
  localparam int EXU_ALU_EBREAK = 11;

  // One-hot positions in the bjp view flag field
  localparam int EXU_BJP_JAL  = 0;
  localparam int EXU_BJP_JALR = 1;
  localparam int EXU_BJP_BEQ  = 2;
  localparam int EXU_BJP_BNE  = 3;
  localparam int EXU_BJP_BLT  = 4;
  localparam int EXU_BJP_BGE  = 5;
  localparam int EXU_BJP_BLTU = 6;
  localparam int EXU_BJP_BGEU = 7;

  // 15-bit execute-info word, read through the view named by its class field
  typedef union packed {
    struct packed {
      logic [ALU_OP_W-1:0] op;
      logic [2:0]          cls;
    } alu;
    struct packed {
      logic [3:0]          pad;
      logic [BJP_OP_W-1:0] op;
      logic [2:0]          cls;
    } bjp;
  } exu_info_t;

endpackage

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
  input  logic [31:0]           inst_i,
  input  rv_core_pkg::xlen_t    pc_i,
  input  rv_core_pkg::xlen_t    rs1_data_i,
  input  rv_core_pkg::xlen_t    rs2_data_i,
  output rv_core_pkg::reg_idx_t rs1_idx_o,
  output rv_core_pkg::reg_idx_t rs2_idx_o,
  output rv_core_pkg::reg_idx_t rd_idx_o,
  output logic                  rd_wr_en_o,
  output rv_core_pkg::xlen_t    op1_o,
  output rv_core_pkg::xlen_t    op2_o,
  output rv_core_pkg::xlen_t    op1_jp_o,
  output rv_core_pkg::xlen_t    op2_jp_o,
  output rv_core_pkg::exu_info_t exu_info_o,
  output logic                  invalid_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [7:0] f3_hot;
  logic       is_op, is_op_imm, is_branch, is_jal, is_jalr, is_lui, is_auipc, is_system;
  logic       f7_zero, f7_alt, shamt_zero, shamt_alt;
  logic       do_add, do_sub, do_sll, do_slt, do_sltu, do_xor;
  logic       do_srl, do_sra, do_or, do_and, do_ebreak;
  logic       do_jal, do_jalr, do_beq, do_bne, do_blt, do_bge, do_bltu, do_bgeu;
  logic       alu_op, bjp_op;
  rv_core_pkg::xlen_t imm_i, imm_b, imm_u, imm_j, imm;

  assign opcode    = inst_i[6:0];
  assign funct7    = inst_i[31:25];
  assign f3_hot    = 8'b1 << inst_i[14:12];
  assign rd_idx_o  = inst_i[11:7];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  // Opcode classes
  assign is_op     = opcode == rv_core_pkg::OPC_OP;
  assign is_op_imm = opcode == rv_core_pkg::OPC_OP_IMM;
  assign is_branch = opcode == rv_core_pkg::OPC_BRANCH;
  assign is_jal    = opcode == rv_core_pkg::OPC_JAL;
  assign is_jalr   = opcode == rv_core_pkg::OPC_JALR;
  assign is_lui    = opcode == rv_core_pkg::OPC_LUI;
  assign is_auipc  = opcode == rv_core_pkg::OPC_AUIPC;
  assign is_system = opcode == rv_core_pkg::OPC_SYSTEM;

  assign f7_zero = funct7 == 7'h00;
  assign f7_alt  = funct7 == 7'h20;
  // RV64 shift immediates carry a 6-bit shamt
  assign shamt_zero = inst_i[31:26] == 6'h00;
  assign shamt_alt  = inst_i[31:26] == 6'h10;

  // ALU class instructions
  assign do_add  = (is_op & f3_hot[0] & f7_zero) | (is_op_imm & f3_hot[0]) | is_auipc;
  assign do_sub  = is_op & f3_hot[0] & f7_alt;
  assign do_sll  = (is_op & f3_hot[1] & f7_zero) | (is_op_imm & f3_hot[1] & shamt_zero);
  assign do_slt  = (is_op & f3_hot[2] & f7_zero) | (is_op_imm & f3_hot[2]);
  assign do_sltu = (is_op & f3_hot[3] & f7_zero) | (is_op_imm & f3_hot[3]);
  assign do_xor  = (is_op & f3_hot[4] & f7_zero) | (is_op_imm & f3_hot[4]);
  assign do_srl  = (is_op & f3_hot[5] & f7_zero) | (is_op_imm & f3_hot[5] & shamt_zero);
  assign do_sra  = (is_op & f3_hot[5] & f7_alt) | (is_op_imm & f3_hot[5] & shamt_alt);
  assign do_or   = (is_op & f3_hot[6] & f7_zero) | (is_op_imm & f3_hot[6]);
  assign do_and  = (is_op & f3_hot[7] & f7_zero) | (is_op_imm & f3_hot[7]);
  assign do_ebreak = is_system & f3_hot[0] & (inst_i[31:20] == 12'h001) &
                     (rs1_idx_o == '0) & (rd_idx_o == '0);

  // Branch and jump class instructions
  assign do_jal  = is_jal;
  assign do_jalr = is_jalr & f3_hot[0];
  assign do_beq  = is_branch & f3_hot[0];
  assign do_bne  = is_branch & f3_hot[1];
  assign do_blt  = is_branch & f3_hot[4];
  assign do_bge  = is_branch & f3_hot[5];
  assign do_bltu = is_branch & f3_hot[6];
  assign do_bgeu = is_branch & f3_hot[7];

  assign alu_op = do_add | do_sub | do_sll | do_slt | do_sltu | do_xor | do_srl |
                  do_sra | do_or | do_and | is_lui | do_ebreak;
  assign bjp_op = do_jal | do_jalr | do_beq | do_bne | do_blt | do_bge | do_bltu | do_bgeu;

  // Loads, stores and anything unrecognised fall through here
  assign invalid_o  = ~(alu_op | bjp_op);
  assign rd_wr_en_o = ((alu_op & ~do_ebreak) | do_jal | do_jalr) & (rd_idx_o != '0);

  // Immediates, U-type already at its architectural position
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    imm = '0;
    if (is_op_imm | do_jalr) begin
      imm = imm_i;
    end else if (is_branch) begin
      imm = imm_b;
    end else if (do_jal) begin
      imm = imm_j;
    end else if (is_lui | is_auipc) begin
      imm = imm_u;
    end
  end

  // Operand selection
  assign op1_o = (is_auipc | do_jal | do_jalr)     ? pc_i :
                 (is_op | is_op_imm | is_branch)   ? rs1_data_i : '0;
  assign op2_o = (do_jal | do_jalr)                ? rv_core_pkg::xlen_t'(4) :
                 (is_op | is_branch)               ? rs2_data_i :
                 (is_op_imm | is_lui | is_auipc)   ? imm : '0;
  assign op1_jp_o = do_jalr                        ? rs1_data_i :
                    (is_branch | do_jal)           ? pc_i : '0;
  assign op2_jp_o = (is_branch | do_jal | do_jalr) ? imm : '0;

  // Info word, filled through the view that matches its class
  always_comb begin
    exu_info_o = '0;
    if (alu_op) begin
      exu_info_o.alu.cls = rv_core_pkg::EXU_CLASS_ALU;
      exu_info_o.alu.op  = {do_ebreak, is_lui, do_and, do_or, do_sra, do_srl,
                            do_xor, do_sltu, do_slt, do_sll, do_sub, do_add};
    end else if (bjp_op) begin
      exu_info_o.bjp.cls = rv_core_pkg::EXU_CLASS_BJP;
      exu_info_o.bjp.op  = {do_bgeu, do_bltu, do_bge, do_blt,
                            do_bne, do_beq, do_jalr, do_jal};
      exu_info_o.bjp.pad = 4'b0;
    end
  end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  rv_core_pkg::reg_idx_t rs1_idx_i,
  input  rv_core_pkg::reg_idx_t rs2_idx_i,
  input  logic                  wr_en_i,
  input  rv_core_pkg::reg_idx_t wr_idx_i,
  input  rv_core_pkg::xlen_t    wr_data_i,
  output rv_core_pkg::xlen_t    rs1_data_o,
  output rv_core_pkg::xlen_t    rs2_data_o
);

  // x0 has no storage
  rv_core_pkg::xlen_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_idx_i != '0)) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  rv_core_pkg::xlen_t     op1_i,
  input  rv_core_pkg::xlen_t     op2_i,
  input  rv_core_pkg::xlen_t     op1_jp_i,
  input  rv_core_pkg::xlen_t     op2_jp_i,
  input  rv_core_pkg::exu_info_t exu_info_i,
  output rv_core_pkg::xlen_t     alu_result_o,
  output logic                   branch_taken_o,
  output rv_core_pkg::xlen_t     jump_target_o,
  output logic                   is_ebreak_o
);

  logic                             is_alu;
  logic                             is_bjp;
  logic [rv_core_pkg::ALU_OP_W-1:0] alu_op;
  logic [rv_core_pkg::BJP_OP_W-1:0] bjp_op;
  logic [5:0]                       shamt;
  rv_core_pkg::xlen_t               add_res;
  rv_core_pkg::xlen_t               jp_sum;
  logic                             op_eq;
  logic                             op_lt;
  logic                             op_ltu;

  // Pick the view from the class field
  assign is_alu = exu_info_i.alu.cls == rv_core_pkg::EXU_CLASS_ALU;
  assign is_bjp = exu_info_i.bjp.cls == rv_core_pkg::EXU_CLASS_BJP;
  assign alu_op = is_alu ? exu_info_i.alu.op : '0;
  assign bjp_op = is_bjp ? exu_info_i.bjp.op : '0;

  assign shamt   = op2_i[5:0];
  assign add_res = op1_i + op2_i;
  assign op_eq   = op1_i == op2_i;
  assign op_lt   = $signed(op1_i) < $signed(op2_i);
  assign op_ltu  = op1_i < op2_i;

  always_comb begin
    case (1'b1)
      // Link value pc+4 for jumps
      is_bjp:                            alu_result_o = add_res;
      alu_op[rv_core_pkg::EXU_ALU_ADD]:  alu_result_o = add_res;
      alu_op[rv_core_pkg::EXU_ALU_SUB]:  alu_result_o = op1_i - op2_i;
      alu_op[rv_core_pkg::EXU_ALU_SLL]:  alu_result_o = op1_i << shamt;
      alu_op[rv_core_pkg::EXU_ALU_SLT]:  alu_result_o = rv_core_pkg::xlen_t'(op_lt);
      alu_op[rv_core_pkg::EXU_ALU_SLTU]: alu_result_o = rv_core_pkg::xlen_t'(op_ltu);
      alu_op[rv_core_pkg::EXU_ALU_XOR]:  alu_result_o = op1_i ^ op2_i;
      alu_op[rv_core_pkg::EXU_ALU_SRL]:  alu_result_o = op1_i >> shamt;
      alu_op[rv_core_pkg::EXU_ALU_SRA]:  alu_result_o = $signed(op1_i) >>> shamt;
      alu_op[rv_core_pkg::EXU_ALU_OR]:   alu_result_o = op1_i | op2_i;
      alu_op[rv_core_pkg::EXU_ALU_AND]:  alu_result_o = op1_i & op2_i;
      alu_op[rv_core_pkg::EXU_ALU_LUI]:  alu_result_o = op2_i;
      default:                           alu_result_o = '0;
    endcase
  end

  // Jumps always taken, branches on compare
  assign branch_taken_o = bjp_op[rv_core_pkg::EXU_BJP_JAL]                 |
                          bjp_op[rv_core_pkg::EXU_BJP_JALR]                |
                          (bjp_op[rv_core_pkg::EXU_BJP_BEQ]  & op_eq)      |
                          (bjp_op[rv_core_pkg::EXU_BJP_BNE]  & ~op_eq)     |
                          (bjp_op[rv_core_pkg::EXU_BJP_BLT]  & op_lt)      |
                          (bjp_op[rv_core_pkg::EXU_BJP_BGE]  & ~op_lt)     |
                          (bjp_op[rv_core_pkg::EXU_BJP_BLTU] & op_ltu)     |
                          (bjp_op[rv_core_pkg::EXU_BJP_BGEU] & ~op_ltu);

  // JALR drops bit 0 of its target
  assign jp_sum        = op1_jp_i + op2_jp_i;
  assign jump_target_o = {jp_sum[rv_core_pkg::XLEN-1:1],
                          jp_sum[0] & ~bjp_op[rv_core_pkg::EXU_BJP_JALR]};

  assign is_ebreak_o = alu_op[rv_core_pkg::EXU_ALU_EBREAK];

endmodule

// ==== hw/rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  inst_valid_i,
  input  logic                  rd_wr_en_i,
  input  rv_core_pkg::reg_idx_t rd_idx_i,
  input  rv_core_pkg::xlen_t    alu_result_i,
  input  rv_core_pkg::xlen_t    jump_target_i,
  input  logic                  branch_taken_i,
  input  logic                  is_ebreak_i,
  input  logic                  invalid_i,
  output rv_core_pkg::xlen_t    pc_o,
  output logic                  wr_en_o,
  output rv_core_pkg::reg_idx_t wr_idx_o,
  output rv_core_pkg::xlen_t    wr_data_o,
  output logic                  wb_valid_o,
  output rv_core_pkg::reg_idx_t wb_idx_o,
  output rv_core_pkg::xlen_t    wb_data_o,
  output logic                  invalid_o,
  output logic                  halt_o
);

  logic               commit;
  rv_core_pkg::xlen_t next_pc;

  // Nothing commits once halted
  assign commit    = inst_valid_i & ~halt_o;
  assign wr_en_o   = commit & rd_wr_en_i;
  assign wr_idx_o  = rd_idx_i;
  assign wr_data_o = alu_result_i;

  assign next_pc = branch_taken_i ? jump_target_i : pc_o + rv_core_pkg::xlen_t'(4);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_o       <= rv_core_pkg::RESET_PC;
      wb_valid_o <= 1'b0;
      invalid_o  <= 1'b0;
      halt_o     <= 1'b0;
    end else begin
      wb_valid_o <= wr_en_o;
      invalid_o  <= commit & invalid_i;
      // Invalid words hold the pc
      if (commit && !invalid_i) begin
        pc_o <= next_pc;
      end
      if (commit && is_ebreak_i) begin
        halt_o <= 1'b1;
      end
    end
  end

  // Write-back report payload
  always_ff @(posedge clk_i) begin
    if (wr_en_o) begin
      wb_idx_o  <= rd_idx_i;
      wb_data_o <= alu_result_i;
    end
  end

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  inst_valid_i,
  input  logic [31:0]           inst_i,
  output rv_core_pkg::xlen_t    pc_o,
  output logic                  wb_valid_o,
  output rv_core_pkg::reg_idx_t wb_idx_o,
  output rv_core_pkg::xlen_t    wb_data_o,
  output logic                  invalid_o,
  output logic                  halt_o
);

  rv_core_pkg::reg_idx_t  rs1_idx, rs2_idx, rd_idx, wr_idx;
  rv_core_pkg::xlen_t     rs1_data, rs2_data, wr_data;
  rv_core_pkg::xlen_t     op1, op2, op1_jp, op2_jp;
  rv_core_pkg::xlen_t     alu_result, jump_target;
  rv_core_pkg::exu_info_t exu_info;
  logic                   rd_wr_en, dec_invalid, branch_taken, is_ebreak, wr_en;

  rv_decode u_decode (
    .inst_i     (inst_i),
    .pc_i       (pc_o),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .rd_idx_o   (rd_idx),
    .rd_wr_en_o (rd_wr_en),
    .op1_o      (op1),
    .op2_o      (op2),
    .op1_jp_o   (op1_jp),
    .op2_jp_o   (op2_jp),
    .exu_info_o (exu_info),
    .invalid_o  (dec_invalid)
  );

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_execute u_execute (
    .op1_i          (op1),
    .op2_i          (op2),
    .op1_jp_i       (op1_jp),
    .op2_jp_i       (op2_jp),
    .exu_info_i     (exu_info),
    .alu_result_o   (alu_result),
    .branch_taken_o (branch_taken),
    .jump_target_o  (jump_target),
    .is_ebreak_o    (is_ebreak)
  );

  rv_result u_result (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_valid_i   (inst_valid_i),
    .rd_wr_en_i     (rd_wr_en),
    .rd_idx_i       (rd_idx),
    .alu_result_i   (alu_result),
    .jump_target_i  (jump_target),
    .branch_taken_i (branch_taken),
    .is_ebreak_i    (is_ebreak),
    .invalid_i      (dec_invalid),
    .pc_o           (pc_o),
    .wr_en_o        (wr_en),
    .wr_idx_o       (wr_idx),
    .wr_data_o      (wr_data),
    .wb_valid_o     (wb_valid_o),
    .wb_idx_o       (wb_idx_o),
    .wb_data_o      (wb_data_o),
    .invalid_o      (invalid_o),
    .halt_o         (halt_o)
  );

endmodule

// ==== verif/rv_core_assertions.sv ====
`timescale 1ns/1ps

module rv_core_assertions (
  input logic               clk_i,
  input logic               reset_i,
  input logic               wb_valid_i,
  input logic               invalid_i,
  input logic               halt_i,
  input rv_core_pkg::xlen_t pc_i
);

  // A commit is either written back or rejected
  wb_or_invalid: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wb_valid_i && invalid_i))
    else $error("wb_valid_o and invalid_o high in the same cycle");

  // Halted core keeps its pc
  pc_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
    halt_i |=> $stable(pc_i))
    else $error("pc_o moved while halt_o was high");

  halt_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    halt_i |=> halt_i)
    else $error("halt_o fell without a reset");

endmodule

bind rv_result rv_core_assertions u_assertions (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .wb_valid_i (wb_valid_o),
  .invalid_i  (invalid_o),
  .halt_i     (halt_o),
  .pc_i       (pc_o)
);

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  // Expected commit for one strobe
  typedef struct packed {
    logic                  wr;
    rv_core_pkg::reg_idx_t idx;
    rv_core_pkg::xlen_t    data;
    rv_core_pkg::xlen_t    pc;
    logic                  inv;
    logic                  hlt;
  } expect_t;

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic                  inst_valid_i;
  logic [31:0]           inst_i;
  rv_core_pkg::xlen_t    pc_o;
  rv_core_pkg::xlen_t    wb_data_o;
  rv_core_pkg::reg_idx_t wb_idx_o;
  logic                  wb_valid_o;
  logic                  invalid_o;
  logic                  halt_o;

  rv_core_pkg::xlen_t    model_regs [32];
  rv_core_pkg::xlen_t    model_pc;
  logic                  model_halt;
  expect_t               exp_q [$];
  int                    errors = 0;
  int                    issued = 0;
  int                    checked = 0;
  int                    n_alu = 300;

  rv_core_top dut0 (.*);

  always #10 clk_i = ~clk_i;

  // Architectural effect of one word on the model state
  function automatic void ref_model(input logic [31:0] w, input rv_core_pkg::xlen_t regs [32],
                                    input rv_core_pkg::xlen_t cur_pc, output expect_t e);
    rv_core_pkg::xlen_t a, b, op2, imm_i, imm_u;
    logic [5:0]         sh;
    logic [2:0]         f3;
    logic               ok;
    logic               take;
    a     = regs[w[19:15]];
    b     = regs[w[24:20]];
    f3    = w[14:12];
    imm_i = 64'($signed(w[31:20]));
    imm_u = 64'($signed({w[31:12], 12'h000}));
    e     = '{1'b1, w[11:7], 64'd0, cur_pc + 64'd4, 1'b0, 1'b0};
    ok    = 1'b1;
    case (w[6:0])
      7'h33, 7'h13: begin
        op2 = w[5] ? b : imm_i;
        sh  = op2[5:0];
        case (f3)
          3'd0: e.data = (w[5] && w[30]) ? a - op2 : a + op2;
          3'd1: e.data = a << sh;
          3'd2: e.data = 64'($signed(a) < $signed(op2));
          3'd3: e.data = 64'(a < op2);
          3'd4: e.data = a ^ op2;
          3'd5: e.data = w[30] ? 64'($signed(a) >>> sh) : a >> sh;
          3'd6: e.data = a | op2;
          default: e.data = a & op2;
        endcase
        // Funct7 rules with a 6-bit shamt for immediate shifts
        if (w[5])
          ok = w[31:25] == 7'h00 || (w[31:25] == 7'h20 && f3 inside {3'd0, 3'd5});
        else if (f3 == 3'd1 || f3 == 3'd5)
          ok = w[31:26] == 6'h00 || (f3 == 3'd5 && w[31:26] == 6'h10);
      end
      7'h37: e.data = imm_u;
      7'h17: e.data = cur_pc + imm_u;
      7'h6f: begin
        e.data = cur_pc + 64'd4;
        e.pc   = cur_pc + 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      end
      7'h67: begin
        ok     = f3 == 3'd0;
        e.data = cur_pc + 64'd4;
        e.pc   = (a + imm_i) & ~64'd1;
      end
      7'h63: begin
        e.wr = 1'b0;
        ok   = f3 != 3'd2 && f3 != 3'd3;
        // Odd funct3 inverts the base compare
        take = f3[2] ? (f3[1] ? a < b : $signed(a) < $signed(b)) : a == b;
        if (take ^ f3[0])
          e.pc = cur_pc + 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      end
      7'h73: begin
        e.wr  = 1'b0;
        ok    = w == 32'h0010_0073;
        e.hlt = ok;
      end
      default: ok = 1'b0;
    endcase
    if (!ok)
      e = '{1'b0, w[11:7], 64'd0, cur_pc, 1'b1, 1'b0};
    if (e.idx == '0)
      e.wr = 1'b0;
  endfunction

  task automatic issue(input logic [31:0] w);
    expect_t e;
    @(posedge clk_i);
    #2;
    ref_model(w, model_regs, model_pc, e);
    // A halted core ignores the strobe
    if (model_halt)
      e = '{1'b0, 5'd0, 64'd0, model_pc, 1'b0, 1'b1};
    if (e.wr)
      model_regs[e.idx] = e.data;
    model_pc   = e.pc;
    model_halt = e.hlt;
    exp_q.push_back(e);
    issued++;
    inst_valid_i = 1'b1;
    inst_i       = w;
  endtask

  task automatic idle();
    @(posedge clk_i);
    #2;
    inst_valid_i = 1'b0;
  endtask

  // ADDI sign-extends its 12 bits, so LUI takes the rounded upper part
  task automatic load_reg(input rv_core_pkg::reg_idx_t rd, input logic [31:0] value);
    issue({value[31:12] + 20'(value[11]), rd, 7'h37});
    issue({value[11:0], rd, 3'd0, rd, 7'h13});
  endtask

  task automatic check_xlen(input string name, input rv_core_pkg::xlen_t act, want);
    if (act !== want) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, want, act);
    end
  endtask

  task automatic check_idx(input string name, input rv_core_pkg::reg_idx_t act, want);
    if (act !== want) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, want, act);
    end
  endtask

  task automatic check_flag(input string name, input logic act, want);
    if (act !== want) begin
      errors++;
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, want, act);
    end
  endtask

  // Compare at the falling edge once the commit outputs have settled
  always @(posedge clk_i) begin : compare
    expect_t e;
    logic    has_inst;
    if (!reset_i) begin
      has_inst = inst_valid_i;
      if (has_inst)
        e = exp_q.pop_front();
      @(negedge clk_i);
      if (wb_valid_o !== (has_inst && e.wr)) begin
        errors++;
        $display("ERROR at %0t ns: wb_valid_o %s", $time,
                 wb_valid_o ? "pulsed with no register write due" : "missing after a write");
      end
      if (has_inst) begin
        if (e.wr && wb_valid_o) begin
          check_idx("wb_idx_o", wb_idx_o, e.idx);
          check_xlen("wb_data_o", wb_data_o, e.data);
        end
        check_xlen("pc_o", pc_o, e.pc);
        check_flag("invalid_o", invalid_o, e.inv);
        check_flag("halt_o", halt_o, e.hlt);
        checked++;
      end else begin
        check_flag("invalid_o", invalid_o, 1'b0);
      end
    end
  end

  initial begin : stimulus
    int unsigned seed;
    logic [2:0]  f3;
    logic [11:0] imm;
    seed         = $urandom(12278);
    reset_i      = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    model_pc     = rv_core_pkg::RESET_PC;
    model_halt   = 1'b0;
    model_regs   = '{default: '0};
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    // Random ALU traffic over registers seeded by LUI/ADDI pairs
    for (int r = 1; r < 32; r++)
      load_reg(5'(r), $urandom);
    repeat (n_alu) begin
      f3  = 3'($urandom);
      imm = 12'($urandom);
      if (f3 == 3'd1 || f3 == 3'd5)
        imm[11:6] = (imm[11] && f3 == 3'd5) ? 6'h10 : 6'h00;
      if ($urandom % 2)
        issue({1'b0, imm[10] && f3 inside {3'd0, 3'd5}, 5'd0, 10'($urandom),
               f3, 5'($urandom), 7'h33});
      else
        issue({imm, 5'($urandom), f3, 5'($urandom), 7'h13});
      if ($urandom % 5 == 0)
        idle();
    end
    // LUI and AUIPC
    repeat (16)
      issue({25'($urandom), ($urandom % 2) ? 7'h37 : 7'h17});
    // Equal, smaller, larger and sign-differing operand pairs
    load_reg(5'd10, 32'd5);
    load_reg(5'd11, 32'd5);
    load_reg(5'd12, 32'd9);
    load_reg(5'd13, 32'hFFFF_FFFD);
    for (int c = 0; c < 8; c++)
      for (int a = 10; a < 14; a++)
        for (int b = 10; b < 14; b++)
          issue({7'($urandom), 5'(b), 5'(a), 3'(c), 5'($urandom), 7'h63});
    repeat (16) begin
      issue({25'($urandom), 7'h6f});
      issue({17'($urandom), 3'd0, 5'($urandom), 7'h67});
    end
    // x0 drops writes and reads back zero
    issue({12'h123, 5'd1, 3'd0, 5'd0, 7'h13});
    issue({12'h000, 5'd0, 3'd0, 5'd7, 7'h13});
    // Load, store, undefined opcode and a MUL word
    issue({12'h010, 5'd2, 3'd3, 5'd3, 7'h03});
    issue({7'h00, 5'd4, 5'd2, 3'd3, 5'd8, 7'h23});
    issue(32'hFFFF_FFFF);
    issue({7'h01, 5'd2, 5'd1, 3'd0, 5'd5, 7'h33});
    issue({7'h00, 5'd0, 5'd3, 3'd0, 5'd9, 7'h33});
    // EBREAK followed by strobes the core must ignore
    issue(32'h0010_0073);
    repeat (4)
      issue({17'($urandom), 3'd0, 5'($urandom), 7'h13});
    idle();
    wait (checked == issued);
    $display("Run complete: %0d instructions, %0d checked, %0d errors", issued, checked, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // About two cycles per random instruction plus the directed set
  initial begin : watchdog
    #((2 * n_alu + 400) * 20);
    $display("ERROR: watchdog expired with %0d of %0d instructions checked", checked, issued);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
hw/rv_core_pkg.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core_top.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv
